//--- hw/rv32i_pkg.sv
package rv32i_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int nregs      = 1 << reg_addr_w;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    // Follows funct3; sra and sub sit on the slt/sltu codes
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        add  = 3'b000,
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101,
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_t;

    typedef enum logic {a1_rs1, a1_pc} alumux1_sel_t;

    typedef enum logic [2:0] {
        a2_i_imm, a2_u_imm, a2_b_imm, a2_s_imm, a2_j_imm, a2_rs2
    } alumux2_sel_t;

    typedef enum logic [1:0] {wb_alu, wb_br_en, wb_u_imm, wb_pc_plus4} wbmux_sel_t;

    typedef enum logic {cmp_rs2, cmp_i_imm} cmpmux_sel_t;

    typedef enum logic [1:0] {pc_next, pc_jump, pc_branch} pcmux_sel_t;

    typedef struct packed {
        rv32i_opcode    opcode;
        alu_ops         aluop;
        branch_funct3_t cmpop;
        alumux1_sel_t   alumux1_sel;
        alumux2_sel_t   alumux2_sel;
        cmpmux_sel_t    cmpmux_sel;
        wbmux_sel_t     wbmux_sel;
        pcmux_sel_t     pcmux_sel;
        logic           reg_write;
        logic           illegal;
    } rv32i_control_word;

endpackage

//--- hw/pipe_intf.sv
`timescale 1ns/1ps

// Decode register contents handed to execute
interface de_bus import rv32i_pkg::*; ();

    typedef struct packed {
        logic [xlen-1:0] i;
        logic [xlen-1:0] s;
        logic [xlen-1:0] b;
        logic [xlen-1:0] u;
        logic [xlen-1:0] j;
    } imm_bundle_t;

    logic                  valid;
    rv32i_control_word     ctw;
    logic [xlen-1:0]       pc;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    imm_bundle_t           imm_bundle;

    modport de_src (output valid, ctw, pc, rd, rs1_data, rs2_data, imm_bundle);
    modport de_dst (input valid, ctw, pc, rd, rs1_data, rs2_data, imm_bundle);

endinterface

// Result of the instruction now in execute
interface ex_bus import rv32i_pkg::*; ();

    logic                  valid;
    logic                  we;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;

    modport ex_src (output valid, we, rd, data);
    modport fwd (input valid, we, rd, data);

endinterface

//--- hw/control_rom.sv
`timescale 1ns/1ps

module control_rom import rv32i_pkg::*; (
    input  rv32i_opcode       opcode,
    input  logic [2:0]        funct3,
    input  logic [6:0]        funct7,
    output rv32i_control_word ctw
);

    arith_funct3_t afunct3;

    assign afunct3 = arith_funct3_t'(funct3);

    always_comb begin : ctw_gen
        ctw.opcode      = opcode;
        ctw.aluop       = alu_ops'(funct3);
        ctw.cmpop       = branch_funct3_t'(funct3);
        ctw.alumux1_sel = a1_rs1;
        ctw.alumux2_sel = a2_i_imm;
        ctw.cmpmux_sel  = cmp_rs2;
        ctw.wbmux_sel   = wb_alu;
        ctw.pcmux_sel   = pc_next;
        ctw.reg_write   = 1'b0;
        ctw.illegal     = 1'b0;

        case (opcode)
            op_lui: begin
                ctw.wbmux_sel = wb_u_imm;
                ctw.reg_write = 1'b1;
            end

            op_auipc: begin
                ctw.aluop       = alu_add;
                ctw.alumux1_sel = a1_pc;
                ctw.alumux2_sel = a2_u_imm;
                ctw.reg_write   = 1'b1;
            end

            op_jal: begin
                ctw.pcmux_sel   = pc_jump;
                ctw.aluop       = alu_add;
                ctw.alumux1_sel = a1_pc;
                ctw.alumux2_sel = a2_j_imm;
                ctw.wbmux_sel   = wb_pc_plus4;
                ctw.reg_write   = 1'b1;
            end

            op_jalr: begin
                ctw.pcmux_sel = pc_jump; // rs1 + i_imm, bit 0 cleared later
                ctw.aluop     = alu_add;
                ctw.wbmux_sel = wb_pc_plus4;
                ctw.reg_write = 1'b1;
            end

            op_br: begin
                ctw.pcmux_sel   = pc_branch;
                ctw.aluop       = alu_add;
                ctw.alumux1_sel = a1_pc;
                ctw.alumux2_sel = a2_b_imm;
            end

            op_load: ctw.aluop = alu_add; // Address only, no data memory

            op_store: begin
                ctw.aluop       = alu_add;
                ctw.alumux2_sel = a2_s_imm;
            end

            op_imm: begin
                ctw.reg_write = 1'b1;
                if (afunct3 == slt || afunct3 == sltu) begin
                    ctw.cmpop      = (afunct3 == slt) ? blt : bltu;
                    ctw.wbmux_sel  = wb_br_en;
                    ctw.cmpmux_sel = cmp_i_imm;
                end else if (afunct3 == sr && funct7 == 7'b0100000) begin
                    ctw.aluop = alu_sra;
                end
            end

            op_reg: begin
                ctw.reg_write   = 1'b1;
                ctw.alumux2_sel = a2_rs2;
                if (afunct3 == slt || afunct3 == sltu) begin
                    ctw.cmpop     = (afunct3 == slt) ? blt : bltu;
                    ctw.wbmux_sel = wb_br_en;
                end else if (afunct3 == sr && funct7 == 7'b0100000) begin
                    ctw.aluop = alu_sra;
                end else if (afunct3 == add && funct7 == 7'b0100000) begin
                    ctw.aluop = alu_sub;
                end
            end

            default: begin
                ctw.illegal   = 1'b1;
                ctw.reg_write = 1'b0;
            end
        endcase
    end

endmodule

//--- hw/regfile.sv
`timescale 1ns/1ps

module regfile import rv32i_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [xlen-1:0]       wdata,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2
);

    logic [xlen-1:0] regs [nregs];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Same-cycle writes are covered by forwarding in decode
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import rv32i_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  instr_valid,
    input  logic [xlen-1:0]       instr,
    input  logic [xlen-1:0]       pc,
    output logic [reg_addr_w-1:0] rs1_addr,
    output logic [reg_addr_w-1:0] rs2_addr,
    input  logic [xlen-1:0]       rs1_rdata,
    input  logic [xlen-1:0]       rs2_rdata,
    ex_bus.fwd                    fwd,
    de_bus.de_src                 de
);

    rv32i_opcode           opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rd;
    rv32i_control_word     ctw;

    logic [xlen-1:0] i_imm;
    logic [xlen-1:0] s_imm;
    logic [xlen-1:0] b_imm;
    logic [xlen-1:0] u_imm;
    logic [xlen-1:0] j_imm;

    logic            fwd_hit1;
    logic            fwd_hit2;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;

    assign opcode   = rv32i_opcode'(instr[6:0]);
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign funct7   = instr[31:25];

    assign i_imm = {{21{instr[31]}}, instr[30:20]};
    assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'h000};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    control_rom u_control_rom (
        .opcode (opcode),
        .funct3 (funct3),
        .funct7 (funct7),
        .ctw    (ctw)
    );

    // Result still in execute overrides the stale register file value
    assign fwd_hit1 = fwd.valid && fwd.we && (rs1_addr == fwd.rd) && (rs1_addr != '0);
    assign fwd_hit2 = fwd.valid && fwd.we && (rs2_addr == fwd.rd) && (rs2_addr != '0);

    assign rs1_val = fwd_hit1 ? fwd.data : rs1_rdata;
    assign rs2_val = fwd_hit2 ? fwd.data : rs2_rdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            de.valid <= 1'b0;
        end else begin
            de.valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            de.ctw          <= ctw;
            de.pc           <= pc;
            de.rd           <= rd;
            de.rs1_data     <= rs1_val;
            de.rs2_data     <= rs2_val;
            de.imm_bundle.i <= i_imm;
            de.imm_bundle.s <= s_imm;
            de.imm_bundle.b <= b_imm;
            de.imm_bundle.u <= u_imm;
            de.imm_bundle.j <= j_imm;
        end
    end

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import rv32i_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    de_bus.de_dst                 de,
    ex_bus.ex_src                 ex,
    output logic                  wb_valid,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic [xlen-1:0]       wb_data,
    output logic                  redirect_valid,
    output logic [xlen-1:0]       redirect_pc,
    output logic                  illegal
);

    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] cmp_b;
    logic            br_en;
    logic [xlen-1:0] wb_val;
    logic            take;
    logic [xlen-1:0] target;

    assign alu_a = (de.ctw.alumux1_sel == a1_pc) ? de.pc : de.rs1_data;

    always_comb begin
        case (de.ctw.alumux2_sel)
            a2_u_imm: alu_b = de.imm_bundle.u;
            a2_b_imm: alu_b = de.imm_bundle.b;
            a2_s_imm: alu_b = de.imm_bundle.s;
            a2_j_imm: alu_b = de.imm_bundle.j;
            a2_rs2:   alu_b = de.rs2_data;
            default:  alu_b = de.imm_bundle.i;
        endcase
    end

    always_comb begin : alu
        case (de.ctw.aluop)
            alu_add: alu_out = alu_a + alu_b;
            alu_sll: alu_out = alu_a << alu_b[4:0];
            alu_sra: alu_out = $signed(alu_a) >>> alu_b[4:0];
            alu_sub: alu_out = alu_a - alu_b;
            alu_xor: alu_out = alu_a ^ alu_b;
            alu_srl: alu_out = alu_a >> alu_b[4:0];
            alu_or:  alu_out = alu_a | alu_b;
            default: alu_out = alu_a & alu_b;
        endcase
    end

    assign cmp_b = (de.ctw.cmpmux_sel == cmp_i_imm) ? de.imm_bundle.i : de.rs2_data;

    always_comb begin : cmp
        case (de.ctw.cmpop)
            beq:     br_en = (de.rs1_data == cmp_b);
            bne:     br_en = (de.rs1_data != cmp_b);
            blt:     br_en = ($signed(de.rs1_data) < $signed(cmp_b));
            bge:     br_en = ($signed(de.rs1_data) >= $signed(cmp_b));
            bltu:    br_en = (de.rs1_data < cmp_b);
            bgeu:    br_en = (de.rs1_data >= cmp_b);
            default: br_en = 1'b0; // funct3 2 and 3 are not branches
        endcase
    end

    always_comb begin
        case (de.ctw.wbmux_sel)
            wb_br_en:    wb_val = {{(xlen-1){1'b0}}, br_en};
            wb_u_imm:    wb_val = de.imm_bundle.u;
            wb_pc_plus4: wb_val = de.pc + 32'd4;
            default:     wb_val = alu_out;
        endcase
    end

    assign ex.valid = de.valid;
    assign ex.we    = de.ctw.reg_write;
    assign ex.rd    = de.rd;
    assign ex.data  = wb_val;

    // Branch and jal targets come straight from the ALU sum
    assign take = de.valid && ((de.ctw.pcmux_sel == pc_jump) ||
                               (de.ctw.pcmux_sel == pc_branch && br_en));
    assign target = (de.ctw.opcode == op_jalr) ? {alu_out[xlen-1:1], 1'b0} : alu_out;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid       <= 1'b0;
            wb_rd          <= '0;
            wb_data        <= '0;
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
            illegal        <= 1'b0;
        end else begin
            wb_valid       <= ex.valid && ex.we;
            redirect_valid <= take;
            illegal        <= de.valid && de.ctw.illegal;
            if (ex.valid && ex.we) begin
                wb_rd   <= ex.rd;
                wb_data <= ex.data;
            end
            if (take) begin
                redirect_pc <= target;
            end
        end
    end

endmodule

//--- hw/rv32i_slice.sv
`timescale 1ns/1ps

module rv32i_slice import rv32i_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  instr_valid,
    input  logic [xlen-1:0]       instr,
    input  logic [xlen-1:0]       pc,
    output logic                  wb_valid,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic [xlen-1:0]       wb_data,
    output logic                  redirect_valid,
    output logic [xlen-1:0]       redirect_pc,
    output logic                  illegal
);

    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [xlen-1:0]       rs1_rdata;
    logic [xlen-1:0]       rs2_rdata;

    de_bus de_if ();
    ex_bus ex_if ();

    decode_stage u_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_rdata   (rs1_rdata),
        .rs2_rdata   (rs2_rdata),
        .fwd         (ex_if.fwd),
        .de          (de_if.de_src)
    );

    execute_stage u_execute (
        .clk            (clk),
        .arst_n         (arst_n),
        .de             (de_if.de_dst),
        .ex             (ex_if.ex_src),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .illegal        (illegal)
    );

    // Write port fed from the execute result, same edge as wb_*
    regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (ex_if.valid && ex_if.we),
        .waddr  (ex_if.rd),
        .wdata  (ex_if.data),
        .raddr1 (rs1_addr),
        .raddr2 (rs2_addr),
        .rdata1 (rs1_rdata),
        .rdata2 (rs2_rdata)
    );

endmodule

//--- include/slice_vectors.svh
`ifndef slice_vectors_svh
`define slice_vectors_svh

// Columns: instr, pc, wb expected, wb rd, wb data, redirect expected, redirect target, illegal
typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wb;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        redir;
    logic [31:0] target;
    logic        ill;
} vec_row_t;

vec_row_t vecs [42] = '{
    '{32'h00500093, 32'h100, 1'b1, 5'd1,  32'h00000005, 1'b0, 32'h000, 1'b0}, // addi x1,x0,5
    '{32'hFFD08113, 32'h104, 1'b1, 5'd2,  32'h00000002, 1'b0, 32'h000, 1'b0}, // addi x2,x1,-3
    '{32'h123451B7, 32'h108, 1'b1, 5'd3,  32'h12345000, 1'b0, 32'h000, 1'b0}, // lui x3,0x12345
    '{32'h00001217, 32'h10C, 1'b1, 5'd4,  32'h0000110C, 1'b0, 32'h000, 1'b0}, // auipc x4,1
    '{32'h004182B3, 32'h110, 1'b1, 5'd5,  32'h1234610C, 1'b0, 32'h000, 1'b0}, // add x5,x3,x4
    '{32'h00708013, 32'h114, 1'b1, 5'd0,  32'h0000000C, 1'b0, 32'h000, 1'b0}, // addi x0,x1,7
    '{32'h00100333, 32'h118, 1'b1, 5'd6,  32'h00000005, 1'b0, 32'h000, 1'b0}, // add x6,x0,x1
    '{32'h402083B3, 32'h11C, 1'b1, 5'd7,  32'h00000003, 1'b0, 32'h000, 1'b0}, // sub x7,x1,x2
    '{32'h0063C433, 32'h120, 1'b1, 5'd8,  32'h00000006, 1'b0, 32'h000, 1'b0}, // xor x8,x7,x6
    '{32'h001464B3, 32'h124, 1'b1, 5'd9,  32'h00000007, 1'b0, 32'h000, 1'b0}, // or x9,x8,x1
    '{32'h0084F533, 32'h128, 1'b1, 5'd10, 32'h00000006, 1'b0, 32'h000, 1'b0}, // and x10,x9,x8
    '{32'h002515B3, 32'h12C, 1'b1, 5'd11, 32'h00000018, 1'b0, 32'h000, 1'b0}, // sll x11,x10,x2
    '{32'h40B00633, 32'h130, 1'b1, 5'd12, 32'hFFFFFFE8, 1'b0, 32'h000, 1'b0}, // sub x12,x0,x11
    '{32'h002656B3, 32'h134, 1'b1, 5'd13, 32'h3FFFFFFA, 1'b0, 32'h000, 1'b0}, // srl x13,x12,x2
    '{32'h40265733, 32'h138, 1'b1, 5'd14, 32'hFFFFFFFA, 1'b0, 32'h000, 1'b0}, // sra x14,x12,x2
    '{32'h00471793, 32'h13C, 1'b1, 5'd15, 32'hFFFFFFA0, 1'b0, 32'h000, 1'b0}, // slli x15,x14,4
    '{32'h01C7D813, 32'h140, 1'b1, 5'd16, 32'h0000000F, 1'b0, 32'h000, 1'b0}, // srli x16,x15,28
    '{32'h4047D893, 32'h144, 1'b1, 5'd17, 32'hFFFFFFFA, 1'b0, 32'h000, 1'b0}, // srai x17,x15,4
    '{32'h00F8C913, 32'h148, 1'b1, 5'd18, 32'hFFFFFFF5, 1'b0, 32'h000, 1'b0}, // xori x18,x17,15
    '{32'h0F097993, 32'h14C, 1'b1, 5'd19, 32'h000000F0, 1'b0, 32'h000, 1'b0}, // andi x19,x18,240
    '{32'h00A9EA13, 32'h150, 1'b1, 5'd20, 32'h000000FA, 1'b0, 32'h000, 1'b0}, // ori x20,x19,10
    '{32'h00162AB3, 32'h154, 1'b1, 5'd21, 32'h00000001, 1'b0, 32'h000, 1'b0}, // slt x21,x12,x1
    '{32'h00163B33, 32'h158, 1'b1, 5'd22, 32'h00000000, 1'b0, 32'h000, 1'b0}, // sltu x22,x12,x1
    '{32'hFFB72B93, 32'h15C, 1'b1, 5'd23, 32'h00000001, 1'b0, 32'h000, 1'b0}, // slti x23,x14,-5
    '{32'hFFF0BC13, 32'h160, 1'b1, 5'd24, 32'h00000001, 1'b0, 32'h000, 1'b0}, // sltiu x24,x1,-1
    '{32'h018B3D33, 32'h164, 1'b1, 5'd26, 32'h00000001, 1'b0, 32'h000, 1'b0}, // sltu x26,x22,x24
    '{32'h00108863, 32'h168, 1'b0, 5'd0,  32'h00000000, 1'b1, 32'h178, 1'b0}, // beq x1,x1,16
    '{32'h00209863, 32'h16C, 1'b0, 5'd0,  32'h00000000, 1'b1, 32'h17C, 1'b0}, // bne x1,x2,16
    '{32'hFE164CE3, 32'h170, 1'b0, 5'd0,  32'h00000000, 1'b1, 32'h168, 1'b0}, // blt x12,x1,-8
    '{32'h00C0D863, 32'h174, 1'b0, 5'd0,  32'h00000000, 1'b1, 32'h184, 1'b0}, // bge x1,x12,16
    '{32'h00C0E863, 32'h178, 1'b0, 5'd0,  32'h00000000, 1'b1, 32'h188, 1'b0}, // bltu x1,x12,16
    '{32'h00167863, 32'h17C, 1'b0, 5'd0,  32'h00000000, 1'b1, 32'h18C, 1'b0}, // bgeu x12,x1,16
    '{32'h00208863, 32'h180, 1'b0, 5'd0,  32'h00000000, 1'b0, 32'h000, 1'b0}, // beq x1,x2 not taken
    '{32'h00C0C863, 32'h184, 1'b0, 5'd0,  32'h00000000, 1'b0, 32'h000, 1'b0}, // blt x1,x12 not taken
    '{32'h00166863, 32'h188, 1'b0, 5'd0,  32'h00000000, 1'b0, 32'h000, 1'b0}, // bltu not taken
    '{32'h02000DEF, 32'h18C, 1'b1, 5'd27, 32'h00000190, 1'b1, 32'h1AC, 1'b0}, // jal x27,32
    '{32'h003D8EE7, 32'h190, 1'b1, 5'd29, 32'h00000194, 1'b1, 32'h192, 1'b0}, // jalr x29,x27,3
    '{32'h04008E67, 32'h194, 1'b1, 5'd28, 32'h00000198, 1'b1, 32'h044, 1'b0}, // jalr x28,x1,64
    '{32'h0000007F, 32'h198, 1'b0, 5'd0,  32'h00000000, 1'b0, 32'h000, 1'b1}, // Undefined opcode
    '{32'h0000AF03, 32'h19C, 1'b0, 5'd0,  32'h00000000, 1'b0, 32'h000, 1'b0}, // lw x30,0(x1)
    '{32'h00112223, 32'h1A0, 1'b0, 5'd0,  32'h00000000, 1'b0, 32'h000, 1'b0}, // sw x1,4(x2)
    '{32'h000F0FB3, 32'h1A4, 1'b1, 5'd31, 32'h00000000, 1'b0, 32'h000, 1'b0}  // x30 never loaded
};

`endif

//--- verif/slice_tb.sv
`timescale 1ns/1ps

module slice_tb import rv32i_pkg::*; ();

    `include "slice_vectors.svh"

    logic                  clk;
    logic                  arst_n;
    logic                  instr_valid;
    logic [xlen-1:0]       instr;
    logic [xlen-1:0]       pc;
    logic                  wb_valid;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_data;
    logic                  redirect_valid;
    logic [xlen-1:0]       redirect_pc;
    logic                  illegal;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int pending [$]; // Row index per issue slot, -1 when idle

    rv32i_slice dut0 (.*);

    always #5 clk = ~clk;

    task automatic expect_equal(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH time %0t: %s is 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
        end
    endtask

    // Outputs of a slot issued two edges earlier
    task automatic score_slot(input int idx);
        vec_row_t row;
        if (idx < 0) begin
            row = '0;
        end else begin
            row = vecs[idx];
        end
        expect_equal("wb_valid", wb_valid, row.wb);
        if (row.wb) begin
            expect_equal("wb_rd", wb_rd, row.rd);
            expect_equal("wb_data", wb_data, row.data);
        end
        expect_equal("redirect_valid", redirect_valid, row.redir);
        if (row.redir) begin
            expect_equal("redirect_pc", redirect_pc, row.target);
        end
        expect_equal("illegal", illegal, row.ill);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > $size(vecs) + 20) begin
            $display("Timeout: the run did not finish within %0d cycles", cycles);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        score_slot(-1); // Nothing issued yet
        expect_equal("wb_rd", wb_rd, 0);
        expect_equal("wb_data", wb_data, 0);
        expect_equal("redirect_pc", redirect_pc, 0);

        for (int i = 0; i < $size(vecs) + 4; i++) begin
            @(negedge clk);
            if (pending.size() == 2) begin
                score_slot(pending.pop_front());
            end
            if (i < $size(vecs)) begin
                instr_valid = 1'b1;
                instr       = vecs[i].instr;
                pc          = vecs[i].pc;
                pending.push_back(i);
            end else begin
                instr_valid = 1'b0; // Drain
                pending.push_back(-1);
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+include
hw/rv32i_pkg.sv
hw/pipe_intf.sv
hw/control_rom.sv
hw/regfile.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/rv32i_slice.sv
verif/slice_tb.sv

//--- Bender.yml
package:
  name: rv32i_slice

sources:
  - hw/rv32i_pkg.sv
  - hw/pipe_intf.sv
  - hw/control_rom.sv
  - hw/regfile.sv
  - hw/decode_stage.sv
  - hw/execute_stage.sv
  - hw/rv32i_slice.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/slice_tb.sv
